// ==== src/loadMissPkg.sv ====
package loadMissPkg;

    localparam int LINE_WORDS_E = 3;
    localparam int INDEX_BITS = 4;
    localparam int WORD_OFFSET_BITS = LINE_WORDS_E;
    localparam int TAG_BITS = 32 - INDEX_BITS - LINE_WORDS_E - 2;
    localparam int SQN_BITS = 6;
    localparam int LINE_ADDR_BITS = TAG_BITS + INDEX_BITS; // word address bits above the line offset.
    localparam int NUM_LINES = 1 << INDEX_BITS;
    localparam int LINE_WORDS = 1 << LINE_WORDS_E;

    localparam int MISSQ_SIZE = 4;
    localparam int MISSQ_SLACK = 2;
    localparam int MISSQ_IDX_BITS = $clog2(MISSQ_SIZE);

    typedef logic [31:0] CacheWord;

    typedef struct packed {
        logic [TAG_BITS-1:0] tag;
        logic [INDEX_BITS-1:0] index;
        logic [WORD_OFFSET_BITS-1:0] wordOffset;
        logic [1:0] byteOffset;
    } AddrFields;

    typedef union packed {
        logic [31:0] flat;
        AddrFields fields;
    } LoadAddr;

    typedef struct packed {
        logic valid;
        logic external;
        logic [SQN_BITS-1:0] sqN;
        LoadAddr addr;
    } LoadUop;

    typedef struct packed {
        logic taken;
        logic [SQN_BITS-1:0] sqN;
    } BranchProv;

    // True for a valid non-external load that is younger than the mispredicted branch.
    function automatic logic isKilled(LoadUop ld, BranchProv br);
        logic [SQN_BITS-1:0] age;
        age = ld.sqN - br.sqN;
        return ld.valid && br.taken && !ld.external && ($signed(age) > 0);
    endfunction

endpackage

// ==== src/cachePortIf.sv ====
`timescale 1ns/1ps

interface cachePortIf import loadMissPkg::*; ();

    logic req;
    logic write;
    LoadAddr addr;
    CacheWord wdata;
    logic grant;
    CacheWord rdata; // valid the cycle after a granted read.
    logic hit;

    modport requester (
        output req, write, addr, wdata,
        input grant, rdata, hit
    );

    modport arbiter (
        input req, write, addr, wdata,
        output grant, rdata, hit
    );

endinterface

// ==== src/cacheArray.sv ====
`timescale 1ns/1ps

module cacheArray import loadMissPkg::*; (
    input logic clk,
    input logic rst,
    cachePortIf.arbiter port
);

    logic [TAG_BITS-1:0] tagMem [NUM_LINES];
    logic [NUM_LINES-1:0][LINE_WORDS-1:0] wordValid; // a line fills word by word.
    CacheWord dataMem [NUM_LINES*LINE_WORDS];
    logic [INDEX_BITS+WORD_OFFSET_BITS-1:0] wordIdx;
    logic [LINE_WORDS-1:0] firstWordMask;
    logic tagMatch;

    assign port.grant = port.req; // the single array port is never busy.
    assign wordIdx = {port.addr.fields.index, port.addr.fields.wordOffset};
    assign tagMatch = tagMem[port.addr.fields.index] == port.addr.fields.tag;
    assign firstWordMask = LINE_WORDS'(1) << port.addr.fields.wordOffset;

    always_ff @(posedge clk) begin
        if (port.req && port.write) begin
            dataMem[wordIdx] <= port.wdata;
            tagMem[port.addr.fields.index] <= port.addr.fields.tag;
        end
        if (port.req && !port.write) begin
            port.rdata <= dataMem[wordIdx];
            port.hit <= tagMatch && wordValid[port.addr.fields.index][port.addr.fields.wordOffset];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wordValid <= '0;
        end else if (port.req && port.write) begin
            if (tagMatch) begin
                wordValid[port.addr.fields.index][port.addr.fields.wordOffset] <= 1'b1;
            end else begin
                wordValid[port.addr.fields.index] <= firstWordMask; // a new tag drops the old words.
            end
        end
    end

endmodule

// ==== src/cacheArbiter.sv ====
`timescale 1ns/1ps

module cacheArbiter (
    input logic clk,
    input logic rst,
    cachePortIf.arbiter fillPort,
    cachePortIf.arbiter replayPort,
    cachePortIf.arbiter newPort
);

    cachePortIf arrayPort();

    logic fillGrant;
    logic replayGrant;
    logic newGrant;
    logic [2:0] readOwner; // one bit per requester, fill in bit 0.

    assign arrayPort.req = fillPort.req || replayPort.req || newPort.req;

    assign fillGrant = fillPort.req && arrayPort.grant;
    assign replayGrant = replayPort.req && !fillPort.req && arrayPort.grant;
    assign newGrant = newPort.req && !fillPort.req && !replayPort.req && arrayPort.grant;

    assign fillPort.grant = fillGrant;
    assign replayPort.grant = replayGrant;
    assign newPort.grant = newGrant;

    always_comb begin
        if (fillPort.req) begin
            arrayPort.write = fillPort.write;
            arrayPort.addr = fillPort.addr;
            arrayPort.wdata = fillPort.wdata;
        end else if (replayPort.req) begin
            arrayPort.write = replayPort.write;
            arrayPort.addr = replayPort.addr;
            arrayPort.wdata = replayPort.wdata;
        end else begin
            arrayPort.write = newPort.write;
            arrayPort.addr = newPort.addr;
            arrayPort.wdata = newPort.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            readOwner <= '0;
        end else begin
            readOwner <= {newGrant && !newPort.write, replayGrant && !replayPort.write,
                          fillGrant && !fillPort.write};
        end
    end

    assign fillPort.rdata = readOwner[0] ? arrayPort.rdata : '0;
    assign fillPort.hit = readOwner[0] && arrayPort.hit;
    assign replayPort.rdata = readOwner[1] ? arrayPort.rdata : '0;
    assign replayPort.hit = readOwner[1] && arrayPort.hit;
    assign newPort.rdata = readOwner[2] ? arrayPort.rdata : '0;
    assign newPort.hit = readOwner[2] && arrayPort.hit;

    cacheArray u_cacheArray (
        .clk(clk),
        .rst(rst),
        .port(arrayPort.arbiter)
    );

endmodule

// ==== src/lineFillEngine.sv ====
`timescale 1ns/1ps

module lineFillEngine import loadMissPkg::*; (
    input logic clk,
    input logic rst,
    input logic missReq,
    input logic [LINE_ADDR_BITS-1:0] missLineAddr,
    output logic memReq,
    output logic [LINE_ADDR_BITS-1:0] memLineAddr,
    input logic memRespValid,
    input CacheWord memRespData,
    output logic fillActive,
    output logic [LINE_ADDR_BITS-1:0] fillLineAddr,
    output logic [WORD_OFFSET_BITS:0] fillProgress,
    cachePortIf.requester port
);

    logic [LINE_ADDR_BITS-1:0] lineAddr;
    logic [WORD_OFFSET_BITS:0] progress; // words written so far.
    logic bufValid;
    CacheWord bufData;
    logic writeTaken;

    assign port.req = bufValid;
    assign port.write = 1'b1;
    assign port.addr = LoadAddr'({lineAddr, progress[WORD_OFFSET_BITS-1:0], 2'b00});
    assign port.wdata = bufData;
    assign writeTaken = bufValid && port.grant;

    assign memLineAddr = lineAddr;
    assign fillLineAddr = lineAddr;
    assign fillProgress = progress;

    always_ff @(posedge clk) begin
        if (rst) begin
            fillActive <= 1'b0;
            memReq <= 1'b0;
            bufValid <= 1'b0;
            progress <= '0;
        end else begin
            memReq <= 1'b0;
            if (!fillActive) begin
                if (missReq) begin
                    fillActive <= 1'b1;
                    memReq <= 1'b1;
                    lineAddr <= missLineAddr;
                    progress <= '0;
                end
            end else begin
                if (writeTaken) begin
                    bufValid <= 1'b0;
                    progress <= progress + 1'b1;
                    if (progress == LINE_WORDS - 1) begin
                        fillActive <= 1'b0; // last word of the line is in.
                    end
                end
                if (memRespValid) begin
                    bufValid <= 1'b1; // a word arriving with the write refills the buffer.
                    bufData <= memRespData;
                end
            end
        end
    end

endmodule

// ==== src/loadMissQueue.sv ====
`timescale 1ns/1ps

module loadMissQueue import loadMissPkg::*; (
    input logic clk,
    input logic rst,
    input BranchProv branch,
    input logic fillIdle,
    input logic fillActive,
    input logic [WORD_OFFSET_BITS:0] fillProgress,
    input logic [LINE_ADDR_BITS-1:0] fillLineAddr,
    input LoadUop ld,
    input logic enqueue,
    output logic full,
    output LoadUop outLd,
    input logic dequeue
);

    LoadUop entryLd [MISSQ_SIZE];
    logic [MISSQ_SIZE-1:0] entryReady;
    logic [MISSQ_IDX_BITS:0] freeCount;
    logic enqFound;
    logic deqFound;
    logic [MISSQ_IDX_BITS-1:0] enqIdx;
    logic [MISSQ_IDX_BITS-1:0] deqIdx;
    logic loadOut;

    // lowest free slot takes the enqueue and lowest eligible entry goes out.
    always_comb begin
        freeCount = '0;
        enqFound = 1'b0;
        enqIdx = '0;
        deqFound = 1'b0;
        deqIdx = '0;
        for (int i = 0; i < MISSQ_SIZE; i++) begin
            if (!entryLd[i].valid) begin
                freeCount = freeCount + 1'b1;
                if (!enqFound) begin
                    enqFound = 1'b1;
                    enqIdx = MISSQ_IDX_BITS'(i);
                end
            end else if (!deqFound && (entryReady[i] || fillIdle) &&
                         !isKilled(entryLd[i], branch)) begin
                deqFound = 1'b1;
                deqIdx = MISSQ_IDX_BITS'(i);
            end
        end
    end

    assign full = freeCount < MISSQ_SLACK;
    assign loadOut = !outLd.valid || dequeue;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < MISSQ_SIZE; i++) begin
                entryLd[i].valid <= 1'b0;
            end
            outLd.valid <= 1'b0;
        end else begin
            for (int i = 0; i < MISSQ_SIZE; i++) begin
                if (isKilled(entryLd[i], branch)) begin
                    entryLd[i].valid <= 1'b0;
                end
                if (fillActive && entryLd[i].valid &&
                    entryLd[i].addr.flat[31 -: LINE_ADDR_BITS] == fillLineAddr &&
                    {1'b0, entryLd[i].addr.fields.wordOffset} < fillProgress) begin
                    entryReady[i] <= 1'b1; // its word is already in the array.
                end
            end
            if (enqueue && ld.valid && enqFound && !isKilled(ld, branch)) begin
                entryLd[enqIdx] <= ld;
                entryReady[enqIdx] <= 1'b0;
            end
            if (dequeue || isKilled(outLd, branch)) begin
                outLd.valid <= 1'b0;
            end
            if (loadOut && deqFound) begin
                outLd <= entryLd[deqIdx];
                entryLd[deqIdx].valid <= 1'b0;
            end
        end
    end

endmodule

// ==== src/loadPipe.sv ====
`timescale 1ns/1ps

module loadPipe import loadMissPkg::*; (
    input logic clk,
    input logic rst,
    input LoadUop ld,
    output logic ldReady,
    input BranchProv branch,
    input logic full,
    input LoadUop replayLd,
    output logic replayDequeue,
    output logic missEnqueue,
    output LoadUop missLd,
    output logic missReq,
    output logic [LINE_ADDR_BITS-1:0] missLineAddr,
    output logic resValid,
    output logic [SQN_BITS-1:0] resSqN,
    output CacheWord resData,
    cachePortIf.requester newPort,
    cachePortIf.requester replayPort
);

    LoadUop issueLd;
    LoadUop newCand;
    LoadUop newFlight;
    LoadUop replayFlight;
    LoadUop flightLd;
    LoadUop respLd;
    logic respHit;
    CacheWord respData;
    logic pipeBusy;
    logic newGranted;

    // new loads wait for an empty pipe so every load in flight has a queue slot.
    assign pipeBusy = newFlight.valid || replayFlight.valid || respLd.valid;
    assign ldReady = !full && !issueLd.valid && !pipeBusy;

    always_comb begin
        newCand = issueLd.valid ? issueLd : ld;
        newCand.valid = issueLd.valid || (ld.valid && ldReady);
    end

    assign newPort.req = newCand.valid;
    assign newPort.write = 1'b0;
    assign newPort.addr = newCand.addr;
    assign newPort.wdata = '0;
    assign newGranted = newCand.valid && newPort.grant;

    assign replayPort.req = replayLd.valid;
    assign replayPort.write = 1'b0;
    assign replayPort.addr = replayLd.addr;
    assign replayPort.wdata = '0;
    assign replayDequeue = replayLd.valid && replayPort.grant;

    // grants are exclusive so at most one read is in flight per cycle.
    assign flightLd = newFlight.valid ? newFlight : replayFlight;

    assign missEnqueue = respLd.valid && !respHit;
    assign missLd = respLd;
    assign missReq = missEnqueue;
    assign missLineAddr = respLd.addr.flat[31 -: LINE_ADDR_BITS];

    always_ff @(posedge clk) begin
        if (rst) begin
            issueLd.valid <= 1'b0;
            newFlight.valid <= 1'b0;
            replayFlight.valid <= 1'b0;
            respLd.valid <= 1'b0;
            resValid <= 1'b0;
        end else begin
            issueLd <= newCand;
            issueLd.valid <= newCand.valid && !newGranted && !isKilled(newCand, branch);
            newFlight <= newCand;
            newFlight.valid <= newGranted && !isKilled(newCand, branch);
            replayFlight <= replayLd;
            replayFlight.valid <= replayDequeue && !isKilled(replayLd, branch);
            respLd <= flightLd;
            respLd.valid <= flightLd.valid && !isKilled(flightLd, branch);
            respHit <= newFlight.valid ? newPort.hit : replayPort.hit;
            respData <= newFlight.valid ? newPort.rdata : replayPort.rdata;
            resValid <= respLd.valid && respHit && !isKilled(respLd, branch);
            resSqN <= respLd.sqN;
            resData <= respData;
        end
    end

endmodule

// ==== src/loadMissTop.sv ====
`timescale 1ns/1ps

module loadMissTop import loadMissPkg::*; (
    input logic clk,
    input logic rst,
    input logic ldValid,
    input logic [31:0] ldAddr,
    input logic [SQN_BITS-1:0] ldSqN,
    input logic ldExternal,
    output logic ldReady,
    input logic branchTaken,
    input logic [SQN_BITS-1:0] branchSqN,
    output logic resValid,
    output logic [SQN_BITS-1:0] resSqN,
    output logic [31:0] resData,
    output logic memReq,
    output logic [LINE_ADDR_BITS-1:0] memLineAddr,
    input logic memRespValid,
    input logic [31:0] memRespData
);

    LoadUop newLd;
    LoadUop replayLd;
    LoadUop missLd;
    BranchProv branch;
    logic full;
    logic replayDequeue;
    logic missEnqueue;
    logic missReq;
    logic [LINE_ADDR_BITS-1:0] missLineAddr;
    logic fillActive;
    logic [LINE_ADDR_BITS-1:0] fillLineAddr;
    logic [WORD_OFFSET_BITS:0] fillProgress;

    cachePortIf fillIf();
    cachePortIf replayIf();
    cachePortIf newIf();

    assign newLd = '{valid: ldValid, external: ldExternal, sqN: ldSqN, addr: LoadAddr'(ldAddr)};
    assign branch = '{taken: branchTaken, sqN: branchSqN};

    loadPipe u_loadPipe (
        .clk(clk), .rst(rst), .ld(newLd), .ldReady(ldReady), .branch(branch), .full(full),
        .replayLd(replayLd), .replayDequeue(replayDequeue),
        .missEnqueue(missEnqueue), .missLd(missLd),
        .missReq(missReq), .missLineAddr(missLineAddr),
        .resValid(resValid), .resSqN(resSqN), .resData(resData),
        .newPort(newIf.requester), .replayPort(replayIf.requester)
    );

    loadMissQueue u_loadMissQueue (
        .clk(clk), .rst(rst), .branch(branch), .fillIdle(!fillActive),
        .fillActive(fillActive), .fillProgress(fillProgress), .fillLineAddr(fillLineAddr),
        .ld(missLd), .enqueue(missEnqueue), .full(full),
        .outLd(replayLd), .dequeue(replayDequeue)
    );

    lineFillEngine u_lineFillEngine (
        .clk(clk), .rst(rst), .missReq(missReq), .missLineAddr(missLineAddr),
        .memReq(memReq), .memLineAddr(memLineAddr),
        .memRespValid(memRespValid), .memRespData(memRespData),
        .fillActive(fillActive), .fillLineAddr(fillLineAddr), .fillProgress(fillProgress),
        .port(fillIf.requester)
    );

    cacheArbiter u_cacheArbiter (
        .clk(clk), .rst(rst),
        .fillPort(fillIf.arbiter), .replayPort(replayIf.arbiter), .newPort(newIf.arbiter)
    );

endmodule

// ==== verification/tbClock.sv ====
`timescale 1ns/1ps

module tbClock (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk; // 20 ns period.
    end

    initial begin
        rst = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0; // released on a falling edge like every other input.
    end

endmodule

// ==== verification/loadMissTb.sv ====
`timescale 1ns/1ps

module loadMissTb import loadMissPkg::*; ();

    localparam int LOAD_BUDGET = 400;
    localparam int TIMEOUT_CYCLES = LOAD_BUDGET * 60 + 1000;
    localparam int SQN_COUNT = 1 << SQN_BITS;
    localparam int LONG_STALL = 16; // longer than any stall the pipe alone can cause.

    logic clk;
    logic rst;
    logic ldValid;
    logic [31:0] ldAddr;
    logic [SQN_BITS-1:0] ldSqN;
    logic ldExternal;
    logic ldReady;
    logic branchTaken;
    logic [SQN_BITS-1:0] branchSqN;
    logic resValid;
    logic [SQN_BITS-1:0] resSqN;
    CacheWord resData;
    logic memReq;
    logic [LINE_ADDR_BITS-1:0] memLineAddr;
    logic memRespValid;
    CacheWord memRespData;

    // the scoreboard keeps one slot per sqN.
    logic pending [SQN_COUNT];
    logic killed [SQN_COUNT];
    logic extFlag [SQN_COUNT];
    CacheWord expData [SQN_COUNT];
    int issueNum [SQN_COUNT];

    integer seed;
    int cycleCount = 0;
    int loadsIssued = 0;
    int killCount = 0;
    int sparedCount = 0;
    int stallCount = 0;
    int stallRun = 0;
    int addrMode = 0;
    int memGapMax = 3;
    int memWordsLeft = 0;
    int memGap = 0;
    int target;
    logic [LINE_ADDR_BITS-1:0] memLine;
    logic [WORD_OFFSET_BITS-1:0] memOffset;
    logic [SQN_BITS-1:0] nextSqN = '0;
    logic [SQN_BITS-1:0] expSqN;
    logic loadTaken = 1'b0;
    logic resultSeen = 1'b0;
    string testName = "reset";

    tbClock u_tbClock (.clk(clk), .rst(rst));

    loadMissTop u_loadMissTop (
        .clk(clk), .rst(rst),
        .ldValid(ldValid), .ldAddr(ldAddr), .ldSqN(ldSqN), .ldExternal(ldExternal),
        .ldReady(ldReady), .branchTaken(branchTaken), .branchSqN(branchSqN),
        .resValid(resValid), .resSqN(resSqN), .resData(resData),
        .memReq(memReq), .memLineAddr(memLineAddr),
        .memRespValid(memRespValid), .memRespData(memRespData)
    );

    // every memory word holds its own word address with a fixed pattern on top.
    function automatic CacheWord memWord(input logic [29:0] wordAddr);
        return {2'b00, wordAddr} ^ 32'hA5A5_0000;
    endfunction

    function automatic int randBelow(input int n);
        return ($random(seed) & 32'h7fff_ffff) % n;
    endfunction

    function automatic int countPending();
        int count;
        count = 0;
        for (int i = 0; i < SQN_COUNT; i++) begin
            if (pending[i]) count++;
        end
        return count;
    endfunction

    // sqN ages must stay well inside half of the sqN space for the kill compare.
    function automatic bit windowOpen();
        for (int i = 0; i < SQN_COUNT; i++) begin
            if (pending[i] && loadsIssued - issueNum[i] >= 24) return 1'b0;
        end
        return countPending() < 32;
    endfunction

    task automatic stopRun();
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic reportError(input string what);
        $display("ERROR: %s", what);
        stopRun();
    endtask

    task automatic checkWord(input string name, input CacheWord expected, input CacheWord actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: expected %h actual %h", name, expected, actual);
            stopRun();
        end
    endtask

    task automatic checkSqN(input string name, input logic [SQN_BITS-1:0] expected,
                            input logic [SQN_BITS-1:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: expected sqN %0d actual sqN %0d", name, expected, actual);
            stopRun();
        end
    endtask

    task automatic takeResult();
        if (addrMode == 1) checkSqN(testName, expSqN, resSqN); // one load at a time here.
        if (!pending[resSqN]) begin
            if (killed[resSqN]) begin
                reportError($sformatf("%s: result for killed load sqN %0d", testName, resSqN));
            end else begin
                reportError($sformatf("%s: result for sqN %0d with no load outstanding",
                                      testName, resSqN));
            end
        end
        checkWord($sformatf("%s sqN %0d", testName, resSqN), expData[resSqN], resData);
        pending[resSqN] = 1'b0;
        resultSeen = 1'b1;
    endtask

    // returns the 8 words of a requested line in order with random gaps.
    task automatic driveMemory();
        memRespValid = 1'b0;
        if (memReq) begin
            memLine = memLineAddr;
            memOffset = '0;
            memWordsLeft = LINE_WORDS;
            memGap = randBelow(memGapMax + 1);
        end
        if (memWordsLeft > 0) begin
            if (memGap == 0) begin
                memRespValid = 1'b1;
                memRespData = memWord({memLine, memOffset});
                memOffset = memOffset + 1'b1;
                memWordsLeft--;
                memGap = randBelow(memGapMax + 1);
            end else begin
                memGap--;
            end
        end
    endtask

    task automatic presentLoad();
        logic [TAG_BITS-1:0] tag;
        logic [INDEX_BITS-1:0] index;
        if (addrMode == 0) begin
            tag = TAG_BITS'(23'h1A0 + randBelow(4));
            index = INDEX_BITS'(randBelow(NUM_LINES));
        end else if (addrMode == 1) begin
            tag = TAG_BITS'(23'h2B0);
            index = INDEX_BITS'(randBelow(3) * 5); // three hot lines.
        end else begin
            tag = TAG_BITS'(23'h3C0 + randBelow(2));
            index = INDEX_BITS'(randBelow(4));
        end
        ldAddr = {tag, index, WORD_OFFSET_BITS'(randBelow(LINE_WORDS)), 2'b00};
        ldSqN = nextSqN;
        ldExternal = (addrMode == 0) && (randBelow(4) == 0);
        ldValid = 1'b1;
    endtask

    task automatic acceptLoad();
        pending[ldSqN] = 1'b1;
        killed[ldSqN] = 1'b0;
        extFlag[ldSqN] = ldExternal;
        expData[ldSqN] = memWord(ldAddr[31:2]);
        issueNum[ldSqN] = loadsIssued;
        loadsIssued++;
        nextSqN = nextSqN + 1'b1;
        loadTaken = 1'b1;
    endtask

    // a taken branch removes every non-external load that is younger than it.
    task automatic killNewer(input logic [SQN_BITS-1:0] brSqN);
        logic signed [SQN_BITS-1:0] age;
        for (int i = 0; i < SQN_COUNT; i++) begin
            age = SQN_BITS'(i) - brSqN;
            if (pending[i] && age > 0) begin
                if (extFlag[i]) begin
                    sparedCount++;
                end else begin
                    pending[i] = 1'b0;
                    killed[i] = 1'b1;
                    killCount++;
                end
            end
        end
    endtask

    task automatic runCycle(input bit offerLoad, input bit offerBranch);
        @(negedge clk);
        if (resValid) takeResult(); // result was registered at the last rising edge.
        driveMemory();
        branchTaken = 1'b0;
        if (loadTaken) begin
            ldValid = 1'b0;
            loadTaken = 1'b0;
        end
        if (offerLoad && !ldValid && windowOpen()) presentLoad();
        if (offerBranch) begin
            branchTaken = 1'b1;
            branchSqN = nextSqN - 1'b1 - SQN_BITS'(randBelow(8));
        end
        if (ldValid && ldReady) acceptLoad(); // taken at the next rising edge.
        if (branchTaken) killNewer(branchSqN);
        if (ldValid && !ldReady) begin
            stallRun++;
            if (stallRun == LONG_STALL) stallCount++;
        end else begin
            stallRun = 0;
        end
    endtask

    task automatic drain();
        while (countPending() != 0 || ldValid) begin
            runCycle(1'b0, 1'b0);
        end
    endtask

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            reportError($sformatf("timeout after %0d cycles in %s with %0d loads outstanding",
                                  cycleCount, testName, countPending()));
        end
    end

    initial begin
        seed = 32'h6574;
        ldValid = 1'b0;
        ldAddr = '0;
        ldSqN = '0;
        ldExternal = 1'b0;
        branchTaken = 1'b0;
        branchSqN = '0;
        memRespValid = 1'b0;
        memRespData = '0;
        for (int i = 0; i < SQN_COUNT; i++) begin
            pending[i] = 1'b0;
            killed[i] = 1'b0;
        end
        @(negedge rst);

        testName = "random";
        while (loadsIssued < 260) begin
            runCycle(randBelow(4) != 0, randBelow(12) == 0);
        end
        drain();
        if (killCount == 0) reportError("no load was killed by a taken branch");
        if (sparedCount == 0) reportError("no external load was younger than a taken branch");

        testName = "hot line";
        addrMode = 1;
        repeat (60) begin
            expSqN = nextSqN;
            resultSeen = 1'b0;
            runCycle(1'b1, 1'b0);
            while (!resultSeen) runCycle(1'b0, 1'b0);
        end

        testName = "back-pressure";
        addrMode = 2;
        memGapMax = 30;
        stallCount = 0;
        stallRun = 0;
        target = loadsIssued + 60;
        while (loadsIssued < target) runCycle(1'b1, 1'b0);
        drain();
        if (stallCount == 0) reportError("ldReady never stayed low while memory was stalled");

        repeat (50) runCycle(1'b0, 1'b0); // late results for killed loads would show here.
        if (countPending() != 0) begin
            reportError($sformatf("%0d loads never produced a result", countPending()));
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

// ==== files.f ====
src/loadMissPkg.sv
src/cachePortIf.sv
src/cacheArray.sv
src/cacheArbiter.sv
src/lineFillEngine.sv
src/loadMissQueue.sv
src/loadPipe.sv
src/loadMissTop.sv
verification/tbClock.sv
verification/loadMissTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= loadMissTb
FILELIST ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --timing -Wno-fatal
PASS_TEXT ?= TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	@out="$$($(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) --lint-only -Wall $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
